/* source/decode_pkg.sv */
package decode_pkg;

    // ISA widths
    localparam int XLEN       = 32;
    localparam int GPR_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;

    // CSR class, opcode in bits 31..24
    localparam logic [7:0] OPC_CSR = 8'h04;

    // Three-register ALU, opcode in bits 31..15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // Immediate ALU, opcode in bits 31..22
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;

    // lu12i.w uses the short opcode in bits 31..25
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // rj field picks the CSR operation, anything else is csrxchg
    localparam logic [GPR_ADDR_W-1:0] CSR_RJ_RD = 5'd0;
    localparam logic [GPR_ADDR_W-1:0] CSR_RJ_WR = 5'd1;

    localparam logic [ALU_OP_W-1:0] OP_NOP     = 8'h00;
    localparam logic [ALU_OP_W-1:0] OP_ADD     = 8'h01;
    localparam logic [ALU_OP_W-1:0] OP_SUB     = 8'h02;
    localparam logic [ALU_OP_W-1:0] OP_SLT     = 8'h03;
    localparam logic [ALU_OP_W-1:0] OP_AND     = 8'h04;
    localparam logic [ALU_OP_W-1:0] OP_OR      = 8'h05;
    localparam logic [ALU_OP_W-1:0] OP_XOR     = 8'h06;
    localparam logic [ALU_OP_W-1:0] OP_LUI     = 8'h07;
    localparam logic [ALU_OP_W-1:0] OP_CSRRD   = 8'h10;
    localparam logic [ALU_OP_W-1:0] OP_CSRWR   = 8'h11;
    localparam logic [ALU_OP_W-1:0] OP_CSRXCHG = 8'h12;

    localparam logic [ALU_SEL_W-1:0] SEL_NOP   = 3'd0;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'd1;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'd2;
    localparam logic [ALU_SEL_W-1:0] SEL_CSR   = 3'd3;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } instr_info_t;

    // Read port 0 sits in the low half of reg_read_addr
    typedef struct packed {
        logic                      hit;
        logic [1:0]                reg_read_valid;
        logic [2*GPR_ADDR_W-1:0]   reg_read_addr;
        logic [XLEN-1:0]           imm;
        logic                      reg_write_valid;
        logic [GPR_ADDR_W-1:0]     reg_write_addr;
        logic [ALU_OP_W-1:0]       aluop;
        logic [ALU_SEL_W-1:0]      alusel;
    } sub_decode_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic [XLEN-1:0] pc;
        sub_decode_t     body;
    } decode_result_t;

endpackage

/* source/decoder_csr.sv */
`timescale 1ns/1ps

// CSR format: opcode[31:24], csr_num[23:10], rj[9:5], rd[4:0]
module decoder_csr
    import decode_pkg::*;
(
    input  instr_info_t instr_info_i,
    output sub_decode_t result_o
);

    logic [XLEN-1:0]       instr;
    logic [GPR_ADDR_W-1:0] rd;
    logic [GPR_ADDR_W-1:0] rj;
    logic [13:0]           csr_num;
    logic                  match;

    assign instr   = instr_info_i.instr;
    assign rd      = instr[4:0];
    assign rj      = instr[9:5];
    assign csr_num = instr[23:10];

    assign match = instr_info_i.valid && (instr[31:24] == OPC_CSR);

    always_comb begin
        result_o = '0;
        if (match) begin
            result_o.hit             = 1'b1;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.imm             = {{(XLEN-14){1'b0}}, csr_num};
            result_o.alusel          = SEL_CSR;
            case (rj)
                CSR_RJ_RD: begin
                    // csrrd only reads the CSR itself
                    result_o.aluop = OP_CSRRD;
                end
                CSR_RJ_WR: begin
                    result_o.aluop          = OP_CSRWR;
                    result_o.reg_read_valid = 2'b01;
                    result_o.reg_read_addr  = {{GPR_ADDR_W{1'b0}}, rd};
                end
                default: begin
                    // csrxchg, rj doubles as the write mask register
                    result_o.aluop          = OP_CSRXCHG;
                    result_o.reg_read_valid = 2'b11;
                    result_o.reg_read_addr  = {rj, rd};
                end
            endcase
        end
    end

endmodule

/* source/decoder_alu_reg.sv */
`timescale 1ns/1ps

// 3R format: opcode[31:15], rk[14:10], rj[9:5], rd[4:0]
module decoder_alu_reg
    import decode_pkg::*;
(
    input  instr_info_t instr_info_i,
    output sub_decode_t result_o
);

    logic [XLEN-1:0]       instr;
    logic [GPR_ADDR_W-1:0] rd;
    logic [GPR_ADDR_W-1:0] rj;
    logic [GPR_ADDR_W-1:0] rk;
    logic                  match;
    logic [ALU_OP_W-1:0]   aluop;
    logic [ALU_SEL_W-1:0]  alusel;

    assign instr = instr_info_i.instr;
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign rk    = instr[14:10];

    // Opcode lookup
    always_comb begin
        match  = 1'b1;
        aluop  = OP_NOP;
        alusel = SEL_NOP;
        case (instr[31:15])
            OPC_ADD_W: begin aluop = OP_ADD; alusel = SEL_ARITH; end
            OPC_SUB_W: begin aluop = OP_SUB; alusel = SEL_ARITH; end
            OPC_SLT:   begin aluop = OP_SLT; alusel = SEL_ARITH; end
            OPC_AND:   begin aluop = OP_AND; alusel = SEL_LOGIC; end
            OPC_OR:    begin aluop = OP_OR;  alusel = SEL_LOGIC; end
            OPC_XOR:   begin aluop = OP_XOR; alusel = SEL_LOGIC; end
            default:   match = 1'b0;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && match) begin
            result_o.hit             = 1'b1;
            // Port 0 gets rj, port 1 gets rk
            result_o.reg_read_valid  = 2'b11;
            result_o.reg_read_addr   = {rk, rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.aluop           = aluop;
            result_o.alusel          = alusel;
        end
    end

endmodule

/* source/decoder_alu_imm.sv */
`timescale 1ns/1ps

// 2RI12 format: opcode[31:22], si12[21:10], rj[9:5], rd[4:0]
// 1RI20 format: opcode[31:25], si20[24:5], rd[4:0]
module decoder_alu_imm
    import decode_pkg::*;
(
    input  instr_info_t instr_info_i,
    output sub_decode_t result_o
);

    logic [XLEN-1:0]       instr;
    logic [GPR_ADDR_W-1:0] rd;
    logic [GPR_ADDR_W-1:0] rj;
    logic [11:0]           imm12;
    logic [19:0]           imm20;

    assign instr = instr_info_i.instr;
    assign rd    = instr[4:0];
    assign rj    = instr[9:5];
    assign imm12 = instr[21:10];
    assign imm20 = instr[24:5];

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid) begin
            // Every hit in this class writes rd
            result_o.reg_write_addr = rd;
            if (instr[31:25] == OPC_LU12I_W) begin
                result_o.hit    = 1'b1;
                result_o.imm    = {imm20, 12'b0};
                result_o.aluop  = OP_LUI;
                result_o.alusel = SEL_ARITH;
            end else begin
                result_o.reg_read_addr = {{GPR_ADDR_W{1'b0}}, rj};
                case (instr[31:22])
                    OPC_ADDI_W: begin
                        result_o.hit    = 1'b1;
                        result_o.imm    = {{(XLEN-12){imm12[11]}}, imm12};
                        result_o.aluop  = OP_ADD;
                        result_o.alusel = SEL_ARITH;
                    end
                    OPC_ANDI: begin
                        result_o.hit    = 1'b1;
                        result_o.imm    = {{(XLEN-12){1'b0}}, imm12};
                        result_o.aluop  = OP_AND;
                        result_o.alusel = SEL_LOGIC;
                    end
                    OPC_ORI: begin
                        result_o.hit    = 1'b1;
                        result_o.imm    = {{(XLEN-12){1'b0}}, imm12};
                        result_o.aluop  = OP_OR;
                        result_o.alusel = SEL_LOGIC;
                    end
                    default: begin
                        result_o.reg_read_addr = '0;
                    end
                endcase
                result_o.reg_read_valid = {1'b0, result_o.hit};
            end
            result_o.reg_write_valid = result_o.hit;
            if (!result_o.hit) begin
                result_o.reg_write_addr = '0;
            end
        end
    end

endmodule

/* source/decode_lane.sv */
`timescale 1ns/1ps

module decode_lane
    import decode_pkg::*;
(
    input  instr_info_t    instr_info_i,
    output decode_result_t result_o
);

    sub_decode_t csr_result;
    sub_decode_t alu_reg_result;
    sub_decode_t alu_imm_result;
    logic        any_hit;

    decoder_csr decoder_csr_i (
        .instr_info_i (instr_info_i),
        .result_o     (csr_result)
    );

    decoder_alu_reg decoder_alu_reg_i (
        .instr_info_i (instr_info_i),
        .result_o     (alu_reg_result)
    );

    decoder_alu_imm decoder_alu_imm_i (
        .instr_info_i (instr_info_i),
        .result_o     (alu_imm_result)
    );

    // Opcode spaces are disjoint, at most one hit per word
    assign any_hit = csr_result.hit | alu_reg_result.hit | alu_imm_result.hit;

    always_comb begin
        result_o.pc = instr_info_i.pc;
        // Non-hitting bodies are zero, so OR acts as the select
        result_o.body    = csr_result | alu_reg_result | alu_imm_result;
        result_o.valid   = instr_info_i.valid & any_hit;
        result_o.illegal = instr_info_i.valid & ~any_hit;
    end

endmodule

/* source/fetch_splitter.sv */
`timescale 1ns/1ps

module fetch_splitter
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        fetch_valid_i,
    input  instr_info_t fetch_packet_i [ISSUE_WIDTH],
    output instr_info_t lane_instr_o   [ISSUE_WIDTH]
);

    instr_info_t slot_q [ISSUE_WIDTH];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                slot_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                // Bubble cycle keeps pc and word, drops the valid bit
                slot_q[k].valid <= fetch_packet_i[k].valid & fetch_valid_i;
                if (fetch_valid_i) begin
                    slot_q[k].pc    <= fetch_packet_i[k].pc;
                    slot_q[k].instr <= fetch_packet_i[k].instr;
                end
            end
        end
    end

    // One slot per lane
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            lane_instr_o[k] = slot_q[k];
        end
    end

endmodule

/* source/decode_collector.sv */
`timescale 1ns/1ps

module decode_collector
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  decode_result_t lane_result_i   [ISSUE_WIDTH],
    output logic           decode_valid_o,
    output decode_result_t decode_packet_o [ISSUE_WIDTH]
);

    logic any_active;

    // Illegal words count too, so the consumer sees them
    always_comb begin
        any_active = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            any_active = any_active | lane_result_i[k].valid | lane_result_i[k].illegal;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            decode_valid_o <= 1'b0;
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                decode_packet_o[k] <= '0;
            end
        end else begin
            decode_valid_o <= any_active;
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                decode_packet_o[k] <= lane_result_i[k];
            end
        end
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fetch_valid_i,
    input  instr_info_t    fetch_packet_i  [ISSUE_WIDTH],
    output logic           decode_valid_o,
    output decode_result_t decode_packet_o [ISSUE_WIDTH]
);

    instr_info_t    lane_instr  [ISSUE_WIDTH];
    decode_result_t lane_result [ISSUE_WIDTH];

    fetch_splitter #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) fetch_splitter_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_packet_i (fetch_packet_i),
        .lane_instr_o   (lane_instr)
    );

    // Lanes are purely combinational between the two registers
    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : lane_gen
        decode_lane lane_i (
            .instr_info_i (lane_instr[k]),
            .result_o     (lane_result[k])
        );
    end

    decode_collector #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) decode_collector_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .lane_result_i   (lane_result),
        .decode_valid_o  (decode_valid_o),
        .decode_packet_o (decode_packet_o)
    );

endmodule

/* testbench/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           fetch_valid_i,
    input instr_info_t    fetch_packet_i  [ISSUE_WIDTH],
    input logic           decode_valid_i,
    input decode_result_t decode_packet_i [ISSUE_WIDTH]
);

    int fail_both    = 0;
    int fail_reset   = 0;
    int fail_latency = 0;
    int fail_count;

    logic any_slot_valid;
    logic any_both_set;

    assign fail_count = fail_both + fail_reset + fail_latency;

    always_comb begin
        any_slot_valid = 1'b0;
        any_both_set   = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            any_slot_valid = any_slot_valid | fetch_packet_i[k].valid;
            any_both_set   = any_both_set
                           | (decode_packet_i[k].valid & decode_packet_i[k].illegal);
        end
    end

    // A slot is either decoded or illegal, never both
    valid_illegal_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !any_both_set
    ) else begin
        fail_both = fail_both + 1;
        $error("a slot has valid and illegal set together");
    end

    reset_quiet: assert property (
        @(posedge clk_i) !rst_n_i |-> !decode_valid_i
    ) else begin
        fail_reset = fail_reset + 1;
        $error("decode_valid_o high during reset");
    end

    // Packet with a live slot shows up two edges later
    latency_two: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ($past(fetch_valid_i, 2) && $past(any_slot_valid, 2)) |-> decode_valid_i
    ) else begin
        fail_latency = fail_latency + 1;
        $error("decode_valid_o missing two cycles after a fetch packet");
    end

endmodule

bind decode_stage decode_checker #(
    .ISSUE_WIDTH (ISSUE_WIDTH)
) checker_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_packet_i  (fetch_packet_i),
    .decode_valid_i  (decode_valid_o),
    .decode_packet_i (decode_packet_o)
);

/* testbench/decode_monitor.sv */
`timescale 1ns/1ps

module decode_monitor
    import decode_pkg::*;
#(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fetch_valid_i,
    input  instr_info_t    fetch_packet_i  [ISSUE_WIDTH],
    input  logic           decode_valid_i,
    input  decode_result_t decode_packet_i [ISSUE_WIDTH],
    output int             error_count_o
);

    int errors = 0;

    decode_result_t model_now [ISSUE_WIDTH];
    decode_result_t exp_q1    [ISSUE_WIDTH];
    decode_result_t exp_q2    [ISSUE_WIDTH];
    logic           model_any;
    logic           exp_valid_q1;
    logic           exp_valid_q2;

    assign error_count_o = errors;

    // Three-register opcode to {aluop, alusel}, zero when unknown
    function automatic logic [ALU_OP_W+ALU_SEL_W-1:0] reg_op_code(input logic [16:0] opc);
        logic [ALU_OP_W+ALU_SEL_W-1:0] code;
        code = '0;
        case (opc)
            OPC_ADD_W: code = {OP_ADD, SEL_ARITH};
            OPC_SUB_W: code = {OP_SUB, SEL_ARITH};
            OPC_SLT:   code = {OP_SLT, SEL_ARITH};
            OPC_AND:   code = {OP_AND, SEL_LOGIC};
            OPC_OR:    code = {OP_OR, SEL_LOGIC};
            OPC_XOR:   code = {OP_XOR, SEL_LOGIC};
            default:   code = '0;
        endcase
        return code;
    endfunction

    function automatic decode_result_t model_decode(input instr_info_t slot);
        decode_result_t res;
        logic [31:0]    w;
        logic [4:0]     rd;
        logic [4:0]     rj;
        logic [4:0]     rk;
        res = '0;
        w   = slot.instr;
        rd  = w[4:0];
        rj  = w[9:5];
        rk  = w[14:10];
        res.pc = slot.pc;
        if (!slot.valid) begin
            return res;
        end
        if (w[31:24] == OPC_CSR) begin
            res.body.hit    = 1'b1;
            res.body.imm    = {18'b0, w[23:10]};
            res.body.alusel = SEL_CSR;
            if (rj == CSR_RJ_RD) begin
                res.body.aluop = OP_CSRRD;
            end else if (rj == CSR_RJ_WR) begin
                res.body.aluop          = OP_CSRWR;
                res.body.reg_read_valid = 2'b01;
                res.body.reg_read_addr  = {5'b0, rd};
            end else begin
                res.body.aluop          = OP_CSRXCHG;
                res.body.reg_read_valid = 2'b11;
                res.body.reg_read_addr  = {rj, rd};
            end
        end else if (reg_op_code(w[31:15]) != '0) begin
            res.body.hit = 1'b1;
            {res.body.aluop, res.body.alusel} = reg_op_code(w[31:15]);
            res.body.reg_read_valid = 2'b11;
            res.body.reg_read_addr  = {rk, rj};
        end else if (w[31:25] == OPC_LU12I_W) begin
            res.body.hit    = 1'b1;
            res.body.imm    = {w[24:5], 12'b0};
            res.body.aluop  = OP_LUI;
            res.body.alusel = SEL_ARITH;
        end else if (w[31:22] == OPC_ADDI_W) begin
            res.body.hit            = 1'b1;
            res.body.imm            = {{20{w[21]}}, w[21:10]};
            res.body.aluop          = OP_ADD;
            res.body.alusel         = SEL_ARITH;
            res.body.reg_read_valid = 2'b01;
            res.body.reg_read_addr  = {5'b0, rj};
        end else if (w[31:22] == OPC_ANDI || w[31:22] == OPC_ORI) begin
            res.body.hit            = 1'b1;
            res.body.imm            = {20'b0, w[21:10]};
            res.body.aluop          = (w[31:22] == OPC_ANDI) ? OP_AND : OP_OR;
            res.body.alusel         = SEL_LOGIC;
            res.body.reg_read_valid = 2'b01;
            res.body.reg_read_addr  = {5'b0, rj};
        end
        // Every legal class writes rd
        if (res.body.hit) begin
            res.body.reg_write_valid = 1'b1;
            res.body.reg_write_addr  = rd;
        end
        res.valid   = res.body.hit;
        res.illegal = !res.body.hit;
        return res;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always_comb begin : model_comb
        instr_info_t slot;
        model_any = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            slot       = fetch_packet_i[k];
            slot.valid = slot.valid & fetch_valid_i;
            model_now[k] = model_decode(slot);
            model_any = model_any | model_now[k].valid | model_now[k].illegal;
        end
    end

    // Two-stage delay line matching the stage latency
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_valid_q1 <= 1'b0;
            exp_valid_q2 <= 1'b0;
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                exp_q1[k] <= '0;
                exp_q2[k] <= '0;
            end
        end else begin
            exp_valid_q1 <= model_any;
            exp_valid_q2 <= exp_valid_q1;
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                exp_q1[k] <= model_now[k];
                exp_q2[k] <= exp_q1[k];
            end
        end
    end

    always @(negedge clk_i) begin
        compare_field("decode_valid", 32'(decode_valid_i), 32'(exp_valid_q2));
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            compare_field($sformatf("slot %0d valid", k),
                          32'(decode_packet_i[k].valid), 32'(exp_q2[k].valid));
            compare_field($sformatf("slot %0d illegal", k),
                          32'(decode_packet_i[k].illegal), 32'(exp_q2[k].illegal));
            if (exp_q2[k].valid || exp_q2[k].illegal) begin
                compare_field($sformatf("slot %0d pc", k), decode_packet_i[k].pc, exp_q2[k].pc);
            end
            compare_field($sformatf("slot %0d hit", k),
                          32'(decode_packet_i[k].body.hit), 32'(exp_q2[k].body.hit));
            compare_field($sformatf("slot %0d reg_read_valid", k),
                          32'(decode_packet_i[k].body.reg_read_valid),
                          32'(exp_q2[k].body.reg_read_valid));
            compare_field($sformatf("slot %0d reg_read_addr", k),
                          32'(decode_packet_i[k].body.reg_read_addr),
                          32'(exp_q2[k].body.reg_read_addr));
            compare_field($sformatf("slot %0d imm", k),
                          decode_packet_i[k].body.imm, exp_q2[k].body.imm);
            compare_field($sformatf("slot %0d reg_write_valid", k),
                          32'(decode_packet_i[k].body.reg_write_valid),
                          32'(exp_q2[k].body.reg_write_valid));
            compare_field($sformatf("slot %0d reg_write_addr", k),
                          32'(decode_packet_i[k].body.reg_write_addr),
                          32'(exp_q2[k].body.reg_write_addr));
            compare_field($sformatf("slot %0d aluop", k),
                          32'(decode_packet_i[k].body.aluop), 32'(exp_q2[k].body.aluop));
            compare_field($sformatf("slot %0d alusel", k),
                          32'(decode_packet_i[k].body.alusel), 32'(exp_q2[k].body.alusel));
        end
    end

endmodule

/* testbench/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int ISSUE_WIDTH  = 2;
    localparam int NUM_PACKETS  = 400;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_PACKETS + 10) * CLK_PERIOD;

    logic           clk_i = 1'b0;
    logic           rst_n_i;
    logic           fetch_valid_i;
    instr_info_t    fetch_packet [ISSUE_WIDTH];
    logic           decode_valid;
    decode_result_t decode_packet [ISSUE_WIDTH];
    int             error_count;
    int             assert_count;
    logic [31:0]    rng_state;
    logic [31:0]    pc_base;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    decode_stage #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) decode_stage_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_packet_i  (fetch_packet),
        .decode_valid_o  (decode_valid),
        .decode_packet_o (decode_packet)
    );

    decode_monitor #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) monitor_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_packet_i  (fetch_packet),
        .decode_valid_i  (decode_valid),
        .decode_packet_i (decode_packet),
        .error_count_o   (error_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic advance_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    // Legal encoding of a random class, fields taken from r
    function automatic logic [31:0] legal_word(input logic [31:0] r, input logic [31:0] sel);
        logic [4:0]  rj;
        logic [16:0] opc3r;
        logic [9:0]  opc_imm;
        case (sel[1:0])
            2'd0: begin
                // Hit all three CSR forms
                case (sel[3:2])
                    2'd0:    rj = CSR_RJ_RD;
                    2'd1:    rj = CSR_RJ_WR;
                    default: rj = r[9:5];
                endcase
                return {OPC_CSR, r[23:10], rj, r[4:0]};
            end
            2'd1: begin
                case (sel[4:2])
                    3'd0:    opc3r = OPC_ADD_W;
                    3'd1:    opc3r = OPC_SUB_W;
                    3'd2:    opc3r = OPC_SLT;
                    3'd3:    opc3r = OPC_AND;
                    3'd4:    opc3r = OPC_OR;
                    default: opc3r = OPC_XOR;
                endcase
                return {opc3r, r[14:0]};
            end
            2'd2: begin
                case (sel[3:2])
                    2'd1:    opc_imm = OPC_ANDI;
                    2'd2:    opc_imm = OPC_ORI;
                    default: opc_imm = OPC_ADDI_W;
                endcase
                return {opc_imm, r[21:0]};
            end
            default: return {OPC_LU12I_W, r[24:0]};
        endcase
    endfunction

    task automatic drive_packet();
        logic [31:0] r_kind;
        logic [31:0] r_word;
        logic [31:0] r_sel;
        advance_random(r_kind);
        // Roughly one bubble in eight cycles
        fetch_valid_i = (r_kind[2:0] != 3'd0);
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            advance_random(r_kind);
            advance_random(r_word);
            advance_random(r_sel);
            fetch_packet[k].pc = pc_base + 32'(4 * k);
            case (r_kind[5:3])
                3'd0, 3'd1, 3'd2, 3'd3, 3'd4: begin
                    fetch_packet[k].valid = 1'b1;
                    fetch_packet[k].instr = legal_word(r_word, r_sel);
                end
                3'd5: begin
                    fetch_packet[k].valid = 1'b1;
                    fetch_packet[k].instr = r_word;
                end
                default: begin
                    fetch_packet[k].valid = 1'b0;
                    fetch_packet[k].instr = r_word;
                end
            endcase
        end
        pc_base = pc_base + 32'(4 * ISSUE_WIDTH);
    endtask

    initial begin : stimulus
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            fetch_packet[k] = '0;
        end
        rng_state = 32'hd70f09e2;
        pc_base   = 32'h1c00_0000;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (int p = 0; p < NUM_PACKETS; p++) begin
            @(posedge clk_i);
            #1;
            drive_packet();
        end
        @(posedge clk_i);
        #1;
        fetch_valid_i = 1'b0;
        // Let the last packet leave the pipeline
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        assert_count = decode_stage_i.checker_i.fail_count;
        $display("Run complete: %0d compare errors, %0d assertion failures",
                 error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

/* project.f */
source/decode_pkg.sv
source/decoder_csr.sv
source/decoder_alu_reg.sv
source/decoder_alu_imm.sv
source/decode_lane.sv
source/fetch_splitter.sv
source/decode_collector.sv
source/decode_stage.sv
testbench/decode_checker.sv
testbench/decode_monitor.sv
testbench/tb_decode_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_decode_stage \
    -f project.f \
    -o sim_decode_stage

# Keep running after assertion errors so the closing report is printed
./obj_dir/sim_decode_stage +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without reported failures"
